/* design/net_rx_cfg.svh */
`ifndef NET_RX_CFG_SVH
`define NET_RX_CFG_SVH

// Beat width of the MAC receive stream
`define NET_DATA_BITS 512

// One byte enable per data byte
`define NET_KEEP_BITS (`NET_DATA_BITS / 8)

// Width of the per-path packet counters
`define NET_CNT_BITS 32

// Byte offsets into the first beat, counted from byte 0 of the frame
// EtherType follows the two MAC addresses
`define ETH_TYPE_OFS 12

// Protocol byte of an IPv4 header without VLAN tag
`define IP_PROTO_OFS 23

// UDP destination port, assuming a 20-byte IPv4 header
`define UDP_DPORT_OFS 36

`endif

/* design/net_rx_pkg.sv */
`include "net_rx_cfg.svh"

package net_rx_pkg;

    // One data beat of the receive stream
    typedef logic [`NET_DATA_BITS-1:0] net_data_t;

    // Byte enables belonging to one beat
    typedef logic [`NET_KEEP_BITS-1:0] net_keep_t;

    // Header fields used by the classifier
    typedef logic [15:0] ethertype_t;
    typedef logic [7:0]  ip_proto_t;
    typedef logic [15:0] udp_port_t;

    // Status counter for completed packets
    typedef logic [`NET_CNT_BITS-1:0] pkt_count_t;

    // Payload of a stream transfer
    // Valid and ready travel beside it as plain signals
    typedef struct packed {
        net_data_t data;
        net_keep_t keep;
        logic      last;
    } net_beat_t;

endpackage

/* design/axis_skid_buffer.sv */
`timescale 1ns/100ps

module axis_skid_buffer (
    input  logic                  nclk,
    input  logic                  nresetn,

    // Upstream side
    input  logic                  s_valid,
    input  net_rx_pkg::net_beat_t s_beat,
    output logic                  s_ready,

    // Downstream side
    output logic                  m_valid,
    output net_rx_pkg::net_beat_t m_beat,
    input  logic                  m_ready
);

    import net_rx_pkg::*;

    // Second storage slot, used only while the output is stalled
    logic      skid_valid;
    net_beat_t skid_beat;

    // Transfer and load conditions
    logic s_xfer;
    logic main_free;
    logic load_from_skid;
    logic load_from_input;
    logic load_skid;

    assign s_xfer = s_valid && s_ready;

    // Main register can take a new beat when empty or being drained
    assign main_free = !m_valid || m_ready;

    // Skid slot always holds the older beat, so it refills main first
    assign load_from_skid  = main_free && skid_valid;
    assign load_from_input = main_free && !skid_valid && s_xfer;

    // Beat arrives while main is stuck
    assign load_skid = !main_free && s_xfer;

    // Ready is taken straight from a flop, no path from m_ready
    assign s_ready = !skid_valid;

    // Occupancy of both slots
    always_ff @(posedge nclk) begin
        if (!nresetn) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (main_free) begin
                // Either refill from skid, take the input, or go empty
                m_valid <= skid_valid || s_xfer;
            end
            if (load_from_skid) begin
                skid_valid <= 1'b0;
            end else if (load_skid) begin
                skid_valid <= 1'b1;
            end
        end
    end

    // Beat payload, no reset needed
    always_ff @(posedge nclk) begin
        if (load_from_skid) begin
            m_beat <= skid_beat;
        end else if (load_from_input) begin
            m_beat <= s_beat;
        end
        if (load_skid) begin
            skid_beat <= s_beat;
        end
    end

    // A stalled output beat must be held until taken
    property p_hold_under_stall;
        @(posedge nclk) disable iff (!nresetn)
            (m_valid && !m_ready) |=> (m_valid && $stable(m_beat));
    endproperty

    a_hold_under_stall: assert property (p_hold_under_stall)
        else $error("skid buffer dropped or changed a stalled beat");

endmodule

/* design/host_networking_prefilter.sv */
`timescale 1ns/100ps
`include "net_rx_cfg.svh"

module host_networking_prefilter (
    input  logic                  nclk,
    input  logic                  nresetn,

    // Run-time offload rules, sampled on first beats only
    input  logic                  roce_offload_en,
    input  logic                  tcp_offload_en,

    // Stream from the input register stage
    input  logic                  in_valid,
    input  net_rx_pkg::net_beat_t in_beat,
    output logic                  in_ready,

    // Host networking path
    output logic                  host_valid,
    output net_rx_pkg::net_beat_t host_beat,
    input  logic                  host_ready,

    // Offload path towards the TCP and RoCE stacks
    output logic                  offload_valid,
    output net_rx_pkg::net_beat_t offload_beat,
    input  logic                  offload_ready
);

    import net_rx_pkg::*;

    // Header values matched by the rules
    localparam ethertype_t ETYPE_IPV4 = 16'h0800;
    localparam ip_proto_t  PROTO_TCP  = 8'd6;
    localparam ip_proto_t  PROTO_UDP  = 8'd17;
    localparam udp_port_t  PORT_ROCE  = 16'd4791;

    // Fields pulled from the current beat
    ethertype_t eth_type;
    ip_proto_t  ip_proto;
    udp_port_t  udp_dport;

    // Classification of the current beat, valid on first beats
    logic is_ipv4;
    logic is_tcp;
    logic is_roce;
    logic offload_hit;

    // Per-packet state
    logic mid_pkt;
    logic offload_flag;
    logic steer_offload;
    logic in_xfer;

    // Network byte order, lower offset is the high byte
    assign eth_type  = {in_beat.data[`ETH_TYPE_OFS*8 +: 8],
                        in_beat.data[(`ETH_TYPE_OFS+1)*8 +: 8]};
    assign ip_proto  = in_beat.data[`IP_PROTO_OFS*8 +: 8];
    assign udp_dport = {in_beat.data[`UDP_DPORT_OFS*8 +: 8],
                        in_beat.data[(`UDP_DPORT_OFS+1)*8 +: 8]};

    assign is_ipv4 = (eth_type == ETYPE_IPV4);
    assign is_tcp  = is_ipv4 && (ip_proto == PROTO_TCP);
    assign is_roce = is_ipv4 && (ip_proto == PROTO_UDP) && (udp_dport == PORT_ROCE);

    // Rules gate the match
    assign offload_hit = (tcp_offload_en && is_tcp) || (roce_offload_en && is_roce);

    // First beat decides on the spot, later beats follow the stored flag
    assign steer_offload = mid_pkt ? offload_flag : offload_hit;

    assign in_xfer = in_valid && in_ready;

    // Any stalled path holds the whole input
    assign in_ready = host_ready && offload_ready;

    // Same beat on both sides, only one valid raised
    // Valid held back until both paths can take it, so a beat leaves once
    assign host_valid    = in_valid && in_ready && !steer_offload;
    assign offload_valid = in_valid && in_ready && steer_offload;
    assign host_beat     = in_beat;
    assign offload_beat  = in_beat;

    // Track packet position and hold the steering decision
    always_ff @(posedge nclk) begin
        if (!nresetn) begin
            mid_pkt      <= 1'b0;
            offload_flag <= 1'b0;
        end else if (in_xfer) begin
            if (in_beat.last) begin
                // Next beat starts a new packet
                mid_pkt      <= 1'b0;
                offload_flag <= 1'b0;
            end else begin
                mid_pkt      <= 1'b1;
                offload_flag <= steer_offload;
            end
        end
    end

    // Exactly one path per beat
    a_one_path: assert property (
        @(posedge nclk) disable iff (!nresetn)
            !(host_valid && offload_valid))
        else $error("beat offered to both host and offload paths");

    // Decision carried unchanged until the packet's final transfer
    property p_steer_stable;
        @(posedge nclk) disable iff (!nresetn)
            (mid_pkt && !(in_xfer && in_beat.last)) |=> (mid_pkt && $stable(offload_flag));
    endproperty

    a_steer_stable: assert property (p_steer_stable)
        else $error("steering changed inside a packet");

endmodule

/* design/rx_path_counters.sv */
`timescale 1ns/100ps

module rx_path_counters (
    input  logic                   nclk,
    input  logic                   nresetn,

    // Handshake and framing seen at the host output
    input  logic                   host_valid,
    input  logic                   host_ready,
    input  logic                   host_last,

    // Handshake and framing seen at the offload output
    input  logic                   offload_valid,
    input  logic                   offload_ready,
    input  logic                   offload_last,

    // Completed packets per path
    output net_rx_pkg::pkt_count_t host_pkt_count,
    output net_rx_pkg::pkt_count_t offload_pkt_count
);

    import net_rx_pkg::*;

    // Packet end on each path
    logic host_done;
    logic offload_done;

    // A packet counts once its final beat has been accepted
    assign host_done    = host_valid && host_ready && host_last;
    assign offload_done = offload_valid && offload_ready && offload_last;

    // Free-running counters, wrap at full scale
    always_ff @(posedge nclk) begin
        if (!nresetn) begin
            host_pkt_count    <= '0;
            offload_pkt_count <= '0;
        end else begin
            if (host_done) begin
                host_pkt_count <= host_pkt_count + pkt_count_t'(1);
            end
            if (offload_done) begin
                offload_pkt_count <= offload_pkt_count + pkt_count_t'(1);
            end
        end
    end

endmodule

/* design/host_rx_path_top.sv */
`timescale 1ns/100ps

module host_rx_path_top (
    input  logic                   nclk,
    input  logic                   nresetn,

    // Offload rule levels
    input  logic                   roce_offload_en,
    input  logic                   tcp_offload_en,

    // Stream from the MAC
    input  logic                   rx_valid,
    input  net_rx_pkg::net_beat_t  rx_beat,
    output logic                   rx_ready,

    // Host networking output
    output logic                   host_valid,
    output net_rx_pkg::net_beat_t  host_beat,
    input  logic                   host_ready,

    // Offload output
    output logic                   offload_valid,
    output net_rx_pkg::net_beat_t  offload_beat,
    input  logic                   offload_ready,

    // Status
    output net_rx_pkg::pkt_count_t host_pkt_count,
    output net_rx_pkg::pkt_count_t offload_pkt_count
);

    import net_rx_pkg::*;

    // Registered input towards the classifier
    logic      in_valid;
    net_beat_t in_beat;
    logic      in_ready;

    // Classifier outputs before the output registers
    logic      pf_host_valid;
    net_beat_t pf_host_beat;
    logic      pf_host_ready;
    logic      pf_offload_valid;
    net_beat_t pf_offload_beat;
    logic      pf_offload_ready;

    // Input register stage
    axis_skid_buffer u_rx_skid (
        .nclk    (nclk),
        .nresetn (nresetn),
        .s_valid (rx_valid),
        .s_beat  (rx_beat),
        .s_ready (rx_ready),
        .m_valid (in_valid),
        .m_beat  (in_beat),
        .m_ready (in_ready)
    );

    // Classify on the first beat and steer the packet
    host_networking_prefilter u_prefilter (
        .nclk            (nclk),
        .nresetn         (nresetn),
        .roce_offload_en (roce_offload_en),
        .tcp_offload_en  (tcp_offload_en),
        .in_valid        (in_valid),
        .in_beat         (in_beat),
        .in_ready        (in_ready),
        .host_valid      (pf_host_valid),
        .host_beat       (pf_host_beat),
        .host_ready      (pf_host_ready),
        .offload_valid   (pf_offload_valid),
        .offload_beat    (pf_offload_beat),
        .offload_ready   (pf_offload_ready)
    );

    // Host output register
    axis_skid_buffer u_host_skid (
        .nclk    (nclk),
        .nresetn (nresetn),
        .s_valid (pf_host_valid),
        .s_beat  (pf_host_beat),
        .s_ready (pf_host_ready),
        .m_valid (host_valid),
        .m_beat  (host_beat),
        .m_ready (host_ready)
    );

    // Offload output register
    axis_skid_buffer u_offload_skid (
        .nclk    (nclk),
        .nresetn (nresetn),
        .s_valid (pf_offload_valid),
        .s_beat  (pf_offload_beat),
        .s_ready (pf_offload_ready),
        .m_valid (offload_valid),
        .m_beat  (offload_beat),
        .m_ready (offload_ready)
    );

    // Counters watch the external handshakes
    rx_path_counters u_counters (
        .nclk              (nclk),
        .nresetn           (nresetn),
        .host_valid        (host_valid),
        .host_ready        (host_ready),
        .host_last         (host_beat.last),
        .offload_valid     (offload_valid),
        .offload_ready     (offload_ready),
        .offload_last      (offload_beat.last),
        .host_pkt_count    (host_pkt_count),
        .offload_pkt_count (offload_pkt_count)
    );

endmodule

/* verification/tb_host_rx_path.sv */
`timescale 1ns/100ps
`include "net_rx_cfg.svh"

module tb_host_rx_path;

    import net_rx_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int PKTS_PER_RULE  = 40;
    localparam int NUM_PKTS       = 4 * PKTS_PER_RULE;
    localparam int TIMEOUT_CYCLES = NUM_PKTS * 4 * 20;
    localparam int MEM_DEPTH      = 1024;

    // Header kinds produced by the generator
    localparam int KIND_TCP   = 0;
    localparam int KIND_ROCE  = 1;
    localparam int KIND_UDP   = 2;
    localparam int KIND_ARP   = 3;
    localparam int KIND_OTHER = 4;

    logic       nclk = 1'b0;
    logic       nresetn = 1'b0;
    logic       roce_offload_en = 1'b0;
    logic       tcp_offload_en = 1'b0;
    logic       rx_valid = 1'b0;
    net_beat_t  rx_beat = '0;
    logic       rx_ready;
    logic       host_valid;
    net_beat_t  host_beat;
    logic       host_ready = 1'b0;
    logic       offload_valid;
    net_beat_t  offload_beat;
    logic       offload_ready = 1'b0;
    pkt_count_t host_pkt_count;
    pkt_count_t offload_pkt_count;

    // Fibonacci LFSR state, x^16 + x^14 + x^13 + x^11 + 1
    logic [15:0] lfsr_state = 16'd55;

    // Expected beats per path, written and read only through NBAs
    net_beat_t  host_mem [0:MEM_DEPTH-1];
    net_beat_t  offload_mem [0:MEM_DEPTH-1];
    int         host_wr = 0;
    int         host_rd = 0;
    int         offload_wr = 0;
    int         offload_rd = 0;
    pkt_count_t exp_host_pkts = '0;
    pkt_count_t exp_offload_pkts = '0;

    // Input side packet tracking
    logic in_mid = 1'b0;
    logic in_offload = 1'b0;
    logic to_offload;

    host_rx_path_top uut (
        .nclk              (nclk),
        .nresetn           (nresetn),
        .roce_offload_en   (roce_offload_en),
        .tcp_offload_en    (tcp_offload_en),
        .rx_valid          (rx_valid),
        .rx_beat           (rx_beat),
        .rx_ready          (rx_ready),
        .host_valid        (host_valid),
        .host_beat         (host_beat),
        .host_ready        (host_ready),
        .offload_valid     (offload_valid),
        .offload_beat      (offload_beat),
        .offload_ready     (offload_ready),
        .host_pkt_count    (host_pkt_count),
        .offload_pkt_count (offload_pkt_count)
    );

    always #(CLK_PERIOD / 2) nclk = ~nclk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // One LFSR step per returned bit, newest bit lands in bit 0
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic net_data_t rand_data();
        net_data_t d;
        d = '0;
        for (int i = 0; i < `NET_DATA_BITS; i++) begin
            d[i] = rand_bits(1) == 32'd1;
        end
        return d;
    endfunction

    // Overlay Ethernet, IPv4 and UDP fields of one kind, byte 0 in bits 7:0
    function automatic net_data_t put_header(input net_data_t d, input int kind);
        net_data_t   h;
        logic [15:0] port;
        logic [7:0]  proto;
        h = d;
        h[`ETH_TYPE_OFS*8 +: 8] = 8'h08;
        h[(`ETH_TYPE_OFS+1)*8 +: 8] = (kind == KIND_ARP) ? 8'h06 : 8'h00;
        case (kind)
            KIND_TCP: begin
                h[`IP_PROTO_OFS*8 +: 8] = 8'd6;
            end
            KIND_ROCE, KIND_UDP: begin
                h[`IP_PROTO_OFS*8 +: 8] = 8'd17;
                // Ports 0x2000..0x2fff never hit 4791
                port = (kind == KIND_ROCE) ? 16'd4791 : {4'h2, 12'(rand_bits(12))};
                h[`UDP_DPORT_OFS*8 +: 8] = port[15:8];
                h[(`UDP_DPORT_OFS+1)*8 +: 8] = port[7:0];
            end
            KIND_OTHER: begin
                proto = 8'(rand_bits(8));
                if (proto == 8'd6 || proto == 8'd17) begin
                    proto = 8'd1;
                end
                h[`IP_PROTO_OFS*8 +: 8] = proto;
            end
            default: begin
            end
        endcase
        return h;
    endfunction

    // Steering rule applied to a first beat
    function automatic logic goes_to_offload(input net_data_t d, input logic tcp_en,
                                             input logic roce_en);
        logic [15:0] etype;
        logic [7:0]  proto;
        logic [15:0] port;
        logic        ipv4;
        etype = {d[`ETH_TYPE_OFS*8 +: 8], d[(`ETH_TYPE_OFS+1)*8 +: 8]};
        proto = d[`IP_PROTO_OFS*8 +: 8];
        port  = {d[`UDP_DPORT_OFS*8 +: 8], d[(`UDP_DPORT_OFS+1)*8 +: 8]};
        ipv4  = etype == 16'h0800;
        return (tcp_en && ipv4 && proto == 8'd6) ||
               (roce_en && ipv4 && proto == 8'd17 && port == 16'd4791);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge nclk);
    endtask

    // Hold the beat until rx_ready is seen at an edge
    task automatic drive_beat(input net_beat_t beat);
        rx_valid <= 1'b1;
        rx_beat  <= beat;
        @(posedge nclk);
        while (!rx_ready) begin
            @(posedge nclk);
        end
        rx_valid <= 1'b0;
        if (rand_bits(2) == 32'd0) begin
            idle_cycles(1 + int'(rand_bits(2)));
        end
    endtask

    task automatic send_packet();
        int        len;
        int        kind;
        int        b;
        net_beat_t beat;
        net_keep_t full_keep;
        full_keep = '1;
        len  = 1 + int'(rand_bits(2));
        kind = int'(rand_bits(3) % 5);
        for (b = 0; b < len; b++) begin
            beat.data = rand_data();
            if (b == 0) begin
                beat.data = put_header(beat.data, kind);
            end else if (rand_bits(1) == 32'd1) begin
                // Decoy TCP or RoCE header inside the packet body
                beat.data = put_header(beat.data, int'(rand_bits(1)));
            end
            beat.last = (b == len - 1);
            beat.keep = beat.last ? (full_keep >> rand_bits(6)) : full_keep;
            drive_beat(beat);
        end
    endtask

    task automatic wait_drained();
        @(posedge nclk);
        while (host_rd != host_wr || offload_rd != offload_wr) begin
            @(posedge nclk);
        end
    endtask

    // Random back-pressure, ready three cycles in four
    always @(posedge nclk) begin
        host_ready    <= (rand_bits(2) != 32'd0);
        offload_ready <= (rand_bits(2) != 32'd0);
    end

    // Input monitor, first beat picks the path for the whole packet
    always @(posedge nclk) begin
        if (nresetn && rx_valid && rx_ready) begin
            to_offload = in_mid ? in_offload
                                : goes_to_offload(rx_beat.data, tcp_offload_en, roce_offload_en);
            if (to_offload) begin
                offload_mem[offload_wr] <= rx_beat;
                offload_wr <= offload_wr + 1;
                if (rx_beat.last) begin
                    exp_offload_pkts <= exp_offload_pkts + 1;
                end
            end else begin
                host_mem[host_wr] <= rx_beat;
                host_wr <= host_wr + 1;
                if (rx_beat.last) begin
                    exp_host_pkts <= exp_host_pkts + 1;
                end
            end
            in_mid     <= !rx_beat.last;
            in_offload <= to_offload;
        end
    end

    // Pop the expected head once an output beat is taken
    always @(posedge nclk) begin
        if (host_valid && host_ready) begin
            host_rd <= host_rd + 1;
        end
        if (offload_valid && offload_ready) begin
            offload_rd <= offload_rd + 1;
        end
    end

    a_host_expected: assert property (@(posedge nclk) disable iff (!nresetn)
        (host_valid && host_ready) |-> (host_rd != host_wr))
        else abort_run("Host output delivered a beat that no packet accounts for");

    a_host_beat: assert property (@(posedge nclk) disable iff (!nresetn)
        (host_valid && host_ready) |-> (host_beat == host_mem[host_rd]))
        else abort_run($sformatf("[FAIL] time %0t host_beat expected %h actual %h",
                                 $time, $sampled(host_mem[host_rd]), $sampled(host_beat)));

    a_offload_expected: assert property (@(posedge nclk) disable iff (!nresetn)
        (offload_valid && offload_ready) |-> (offload_rd != offload_wr))
        else abort_run("Offload output delivered a beat that no packet accounts for");

    a_offload_beat: assert property (@(posedge nclk) disable iff (!nresetn)
        (offload_valid && offload_ready) |-> (offload_beat == offload_mem[offload_rd]))
        else abort_run($sformatf("[FAIL] time %0t offload_beat expected %h actual %h",
                                 $time, $sampled(offload_mem[offload_rd]),
                                 $sampled(offload_beat)));

    // Watchdog sized from packet count, 4 beats, 20 cycles per beat
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired before all packets left the DUT");
    end

    initial begin
        int rule;
        repeat (10) @(posedge nclk);
        nresetn <= 1'b1;
        @(posedge nclk);
        assert (!host_valid && !offload_valid && rx_ready)
            else abort_run("Outputs not idle or rx_ready low after reset");
        assert (host_pkt_count == '0 && offload_pkt_count == '0)
            else abort_run("Packet counters not zero after reset");

        // Bit 0 enables TCP offload, bit 1 RoCE offload
        for (rule = 0; rule < 4; rule++) begin
            tcp_offload_en  <= rule[0];
            roce_offload_en <= rule[1];
            @(posedge nclk);
            repeat (PKTS_PER_RULE) send_packet();
            wait_drained();
        end

        // Counters follow the last tlast handshake by one edge
        idle_cycles(4);
        assert (host_rd == host_wr && offload_rd == offload_wr)
            else abort_run("Expected beats left over at end of test");
        assert (host_pkt_count == exp_host_pkts)
            else abort_run($sformatf("[FAIL] time %0t host_pkt_count expected %0d actual %0d",
                                     $time, exp_host_pkts, host_pkt_count));
        assert (offload_pkt_count == exp_offload_pkts)
            else abort_run($sformatf("[FAIL] time %0t offload_pkt_count expected %0d actual %0d",
                                     $time, exp_offload_pkts, offload_pkt_count));
        $display("TEST PASS");
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
design/net_rx_pkg.sv
design/axis_skid_buffer.sv
design/host_networking_prefilter.sv
design/rx_path_counters.sv
design/host_rx_path_top.sv
verification/tb_host_rx_path.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the receive path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_host_rx_path \
    -f flist.f

# The log decides the result, so a fatal exit must not stop the script here
./obj_dir/Vtb_host_rx_path > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
